// File: source/ltpi_tx_pkg.sv
package ltpi_tx_pkg;

    // ----------------------------------------
    // Link training state, driven from outside
    // ----------------------------------------
    typedef enum logic [3:0] {
        st_init,
        st_comma_hunting,
        st_wait_link_detect_locked,
        st_wait_link_speed_locked,
        st_link_speed_change,
        st_wait_link_advertise_locked,
        st_wait_in_advertise,
        st_operational,
        st_link_lost_err
    } link_state_t;

    // Speed multipliers, same order as the capability bits
    typedef enum logic [3:0] {
        base_freq_x1,
        base_freq_x2,
        base_freq_x3,
        base_freq_x4,
        base_freq_x6,
        base_freq_x8,
        base_freq_x10,
        base_freq_x12,
        base_freq_x16,
        base_freq_x24,
        base_freq_x32,
        base_freq_x40
    } link_speed_t;

    // ----------------------------------------
    // Frame data types
    // ----------------------------------------
    typedef logic [7:0]   frm_byte_t;
    typedef logic [3:0]   frm_offset_t;

    // Bits 0..11 follow link_speed_t, bit 15 is DDR
    typedef logic [15:0]  speed_capab_t;

    // Byte k sits at bits [8k+7:8k]
    typedef logic [119:0] frame_t;

    localparam int FRAME_BYTES = 15;
    localparam frm_offset_t FRAME_END_OFFSET = 4'd15;

    // ----------------------------------------
    // Symbols
    // ----------------------------------------
    localparam frm_byte_t K28_5 = 8'hBC;
    localparam frm_byte_t K28_6 = 8'hDC;

    localparam frm_byte_t SUB_DETECT    = 8'h00;
    localparam frm_byte_t SUB_SPEED     = 8'h01;
    localparam frm_byte_t SUB_ADVERTISE = 8'h00;

    localparam frm_byte_t LTPI_VERSION       = 8'h01;
    localparam frm_byte_t CAPAB_TYPE_DEFAULT = 8'h00;

    // Frame count thresholds
    localparam int DETECT_DONE_CNT   = 255;
    localparam int SPEED_DONE_CNT    = 7;
    localparam int SPEED_TIMEOUT_CNT = 32;

    // Counter widths
    localparam int DETECT_CNT_W = 16;
    localparam int SPEED_CNT_W  = 8;
    localparam int FRAME_CNT_W  = 32;

endpackage

// File: source/link_speed_resolver.sv
module link_speed_resolver (
    input  logic                      clk,
    input  logic                      reset,
    input  ltpi_tx_pkg::link_state_t  link_state,
    input  ltpi_tx_pkg::speed_capab_t local_speed_capab,
    input  ltpi_tx_pkg::speed_capab_t remote_speed_capab,
    output ltpi_tx_pkg::speed_capab_t speed_select,
    output ltpi_tx_pkg::link_speed_t  operational_speed,
    output logic                      ddr_mode
);
    import ltpi_tx_pkg::*;

    logic        speed_found;
    link_speed_t speed_next;

    // Capabilities shared by both ends
    assign speed_select = local_speed_capab & remote_speed_capab;

    // Highest common speed bit wins
    always_comb begin
        speed_found = 1'b0;
        speed_next  = base_freq_x1;
        for (int i = 0; i <= int'(base_freq_x40); i++) begin
            if (speed_select[i]) begin
                speed_found = 1'b1;
                speed_next  = link_speed_t'(i[3:0]);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            operational_speed <= base_freq_x1;
            ddr_mode          <= 1'b0;
        end else if (link_state == st_init) begin
            operational_speed <= base_freq_x1;
            ddr_mode          <= 1'b0;
        end else if (link_state == st_link_lost_err) begin
            operational_speed <= base_freq_x1;
        end else if (link_state == st_wait_link_detect_locked) begin
            if (speed_found) begin
                operational_speed <= speed_next;
            end
            ddr_mode <= speed_select[15];
        end
    end

endmodule

// File: source/frame_byte_generator.sv
module frame_byte_generator (
    input  ltpi_tx_pkg::link_state_t  link_state,
    input  ltpi_tx_pkg::frm_offset_t  frm_offset,
    input  ltpi_tx_pkg::speed_capab_t local_speed_capab,
    input  ltpi_tx_pkg::speed_capab_t speed_select,
    input  logic [15:0]               platform_id,
    input  logic [63:0]               advertise_capab,
    input  ltpi_tx_pkg::frame_t       operational_frame,
    output logic                      byte_wr,
    output ltpi_tx_pkg::frm_offset_t  byte_index,
    output ltpi_tx_pkg::frm_byte_t    byte_value
);
    import ltpi_tx_pkg::*;

    logic         speed_frame;
    speed_capab_t training_capab;
    logic [2:0]   adv_index;

    // Detect and speed frames share one layout
    assign speed_frame = (link_state == st_wait_link_speed_locked) ||
                         (link_state == st_link_speed_change);
    assign training_capab = speed_frame ? speed_select : local_speed_capab;

    // Advertise capability bytes start at offset 5
    assign adv_index = 3'(frm_offset - 4'd5);

    assign byte_index = frm_offset;

    always_comb begin
        byte_wr    = 1'b0;
        byte_value = '0;
        case (link_state)
            st_comma_hunting, st_wait_link_detect_locked,
            st_wait_link_speed_locked, st_link_speed_change: begin
                byte_wr = (frm_offset <= 4'd4);
                case (frm_offset)
                    4'd0: byte_value = K28_5;
                    4'd1: byte_value = speed_frame ? SUB_SPEED : SUB_DETECT;
                    4'd2: byte_value = LTPI_VERSION;
                    4'd3: byte_value = training_capab[7:0];
                    4'd4: byte_value = training_capab[15:8];
                    default: byte_value = '0;
                endcase
            end
            st_wait_link_advertise_locked, st_wait_in_advertise: begin
                byte_wr = (frm_offset != FRAME_END_OFFSET);
                case (frm_offset)
                    4'd0: byte_value = K28_6;
                    4'd1: byte_value = SUB_ADVERTISE;
                    4'd2: byte_value = platform_id[15:8];
                    4'd3: byte_value = platform_id[7:0];
                    4'd4: byte_value = CAPAB_TYPE_DEFAULT;
                    4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd10, 4'd11, 4'd12: begin
                        byte_value = advertise_capab[{adv_index, 3'b000} +: 8];
                    end
                    // Data 11 and 12 are reserved
                    default: byte_value = '0;
                endcase
            end
            st_operational: begin
                if (frm_offset != FRAME_END_OFFSET) begin
                    byte_wr    = 1'b1;
                    byte_value = operational_frame[{frm_offset, 3'b000} +: 8];
                end
            end
            default: begin
                byte_wr = 1'b0;
            end
        endcase
    end

endmodule

// File: source/tx_frame_buffer.sv
module tx_frame_buffer (
    input  logic                     clk,
    input  logic                     reset,
    input  ltpi_tx_pkg::link_state_t link_state,
    input  logic                     byte_wr,
    input  ltpi_tx_pkg::frm_offset_t byte_index,
    input  ltpi_tx_pkg::frm_byte_t   byte_value,
    output ltpi_tx_pkg::frame_t      frame_tx
);
    import ltpi_tx_pkg::*;

    frm_byte_t frame_bytes [FRAME_BYTES];

    // Bytes not rewritten keep the previous frame's contents
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < FRAME_BYTES; i++) begin
                frame_bytes[i] <= '0;
            end
        end else if (link_state == st_init || link_state == st_link_lost_err) begin
            for (int i = 0; i < FRAME_BYTES; i++) begin
                frame_bytes[i] <= '0;
            end
        end else if (byte_wr) begin
            frame_bytes[byte_index] <= byte_value;
        end
    end

    // Flatten, byte 0 in the low bits
    for (genvar i = 0; i < FRAME_BYTES; i++) begin : g_flatten
        assign frame_tx[8*i +: 8] = frame_bytes[i];
    end

endmodule

// File: source/frame_sent_tracker.sv
module frame_sent_tracker (
    input  logic                                  clk,
    input  logic                                  reset,
    input  ltpi_tx_pkg::link_state_t              link_state,
    input  ltpi_tx_pkg::frm_offset_t              frm_offset,
    output logic [ltpi_tx_pkg::DETECT_CNT_W-1:0]  detect_frm_cnt,
    output logic [ltpi_tx_pkg::SPEED_CNT_W-1:0]   speed_frm_cnt,
    output logic [ltpi_tx_pkg::FRAME_CNT_W-1:0]   advertise_frm_cnt,
    output logic [ltpi_tx_pkg::FRAME_CNT_W-1:0]   operational_frm_cnt,
    output logic                                  detect_frames_done,
    output logic                                  speed_frames_done,
    output logic                                  speed_timeout
);
    import ltpi_tx_pkg::*;

    logic link_clear;
    logic frame_end_seen;
    logic frame_end;

    assign link_clear = (link_state == st_init) || (link_state == st_link_lost_err);

    // Count once per run of the last offset
    assign frame_end = (frm_offset == FRAME_END_OFFSET) && !frame_end_seen;

    // ----------------------------------------
    // Frame counters
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_end_seen      <= 1'b0;
            detect_frm_cnt      <= '0;
            speed_frm_cnt       <= '0;
            advertise_frm_cnt   <= '0;
            operational_frm_cnt <= '0;
        end else if (link_clear) begin
            frame_end_seen      <= 1'b0;
            detect_frm_cnt      <= '0;
            speed_frm_cnt       <= '0;
            advertise_frm_cnt   <= '0;
            operational_frm_cnt <= '0;
        end else begin
            frame_end_seen <= (frm_offset == FRAME_END_OFFSET);
            if (frame_end) begin
                case (link_state)
                    // Comma hunting frames are not counted
                    st_wait_link_detect_locked: detect_frm_cnt <= detect_frm_cnt + 1'b1;
                    st_wait_link_speed_locked, st_link_speed_change: begin
                        speed_frm_cnt <= speed_frm_cnt + 1'b1;
                    end
                    st_wait_link_advertise_locked, st_wait_in_advertise: begin
                        advertise_frm_cnt <= advertise_frm_cnt + 1'b1;
                    end
                    st_operational: operational_frm_cnt <= operational_frm_cnt + 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // ----------------------------------------
    // Status flags
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            detect_frames_done <= 1'b0;
            speed_frames_done  <= 1'b0;
            speed_timeout      <= 1'b0;
        end else begin
            detect_frames_done <= (detect_frm_cnt >= DETECT_DONE_CNT);
            if (link_clear) begin
                speed_frames_done <= 1'b0;
                speed_timeout     <= 1'b0;
            end else begin
                speed_frames_done <= (speed_frm_cnt >= SPEED_DONE_CNT);
                // Sticky until the link restarts
                if (speed_frm_cnt >= SPEED_TIMEOUT_CNT) begin
                    speed_timeout <= 1'b1;
                end
            end
        end
    end

endmodule

// File: source/ltpi_frame_tx.sv
module ltpi_frame_tx (
    input  logic                                  clk,
    input  logic                                  reset,
    input  ltpi_tx_pkg::link_state_t              link_state,
    input  ltpi_tx_pkg::frm_offset_t              frm_offset,
    input  ltpi_tx_pkg::speed_capab_t             local_speed_capab,
    input  ltpi_tx_pkg::speed_capab_t             remote_speed_capab,
    input  logic [15:0]                           platform_id,
    input  logic [63:0]                           advertise_capab,
    input  ltpi_tx_pkg::frame_t                   operational_frame,
    output ltpi_tx_pkg::frame_t                   frame_tx,
    output logic [ltpi_tx_pkg::DETECT_CNT_W-1:0]  detect_frm_cnt,
    output logic [ltpi_tx_pkg::SPEED_CNT_W-1:0]   speed_frm_cnt,
    output logic [ltpi_tx_pkg::FRAME_CNT_W-1:0]   advertise_frm_cnt,
    output logic [ltpi_tx_pkg::FRAME_CNT_W-1:0]   operational_frm_cnt,
    output logic                                  detect_frames_done,
    output logic                                  speed_frames_done,
    output logic                                  speed_timeout,
    output ltpi_tx_pkg::link_speed_t              operational_speed,
    output logic                                  ddr_mode
);
    import ltpi_tx_pkg::*;

    speed_capab_t speed_select;
    logic         byte_wr;
    frm_offset_t  byte_index;
    frm_byte_t    byte_value;

    link_speed_resolver link_speed_resolver_i (
        .clk                (clk),
        .reset              (reset),
        .link_state         (link_state),
        .local_speed_capab  (local_speed_capab),
        .remote_speed_capab (remote_speed_capab),
        .speed_select       (speed_select),
        .operational_speed  (operational_speed),
        .ddr_mode           (ddr_mode)
    );

    frame_byte_generator frame_byte_generator_i (
        .link_state        (link_state),
        .frm_offset        (frm_offset),
        .local_speed_capab (local_speed_capab),
        .speed_select      (speed_select),
        .platform_id       (platform_id),
        .advertise_capab   (advertise_capab),
        .operational_frame (operational_frame),
        .byte_wr           (byte_wr),
        .byte_index        (byte_index),
        .byte_value        (byte_value)
    );

    tx_frame_buffer tx_frame_buffer_i (
        .clk        (clk),
        .reset      (reset),
        .link_state (link_state),
        .byte_wr    (byte_wr),
        .byte_index (byte_index),
        .byte_value (byte_value),
        .frame_tx   (frame_tx)
    );

    frame_sent_tracker frame_sent_tracker_i (
        .clk                 (clk),
        .reset               (reset),
        .link_state          (link_state),
        .frm_offset          (frm_offset),
        .detect_frm_cnt      (detect_frm_cnt),
        .speed_frm_cnt       (speed_frm_cnt),
        .advertise_frm_cnt   (advertise_frm_cnt),
        .operational_frm_cnt (operational_frm_cnt),
        .detect_frames_done  (detect_frames_done),
        .speed_frames_done   (speed_frames_done),
        .speed_timeout       (speed_timeout)
    );

endmodule

// File: verification/tb_ltpi_frame_tx.sv
module tb_ltpi_frame_tx;
    timeunit 1ns;
    timeprecision 100ps;
    import ltpi_tx_pkg::*;

    // Frames per test step, used for the run limit
    localparam int HUNT_FRAMES = 3;
    localparam int DETECT_FRAMES = 256;
    localparam int SPEED_LOCK_FRAMES = 20;
    localparam int SPEED_CHANGE_FRAMES = 14;
    localparam int ADV_FRAMES = 4;
    localparam int OP_FRAMES = 8;
    localparam int CLEAR_FRAMES = 2;
    localparam int TOTAL_FRAMES = HUNT_FRAMES + DETECT_FRAMES + SPEED_LOCK_FRAMES +
                                  SPEED_CHANGE_FRAMES + 2 * ADV_FRAMES + OP_FRAMES +
                                  2 * CLEAR_FRAMES;
    localparam int CYCLE_LIMIT = TOTAL_FRAMES * 16 + 64;

    logic         clk;
    logic         reset;
    link_state_t  link_state;
    frm_offset_t  frm_offset;
    speed_capab_t local_speed_capab;
    speed_capab_t remote_speed_capab;
    logic [15:0]  platform_id;
    logic [63:0]  advertise_capab;
    frame_t       operational_frame;
    frame_t       frame_tx;
    logic [DETECT_CNT_W-1:0] detect_frm_cnt;
    logic [SPEED_CNT_W-1:0]  speed_frm_cnt;
    logic [FRAME_CNT_W-1:0]  advertise_frm_cnt;
    logic [FRAME_CNT_W-1:0]  operational_frm_cnt;
    logic         detect_frames_done;
    logic         speed_frames_done;
    logic         speed_timeout;
    link_speed_t  operational_speed;
    logic         ddr_mode;

    // Reference model state
    frame_t       m_frame;
    logic         m_end_seen;
    logic [DETECT_CNT_W-1:0] m_detect_cnt;
    logic [SPEED_CNT_W-1:0]  m_speed_cnt;
    logic [FRAME_CNT_W-1:0]  m_adv_cnt;
    logic [FRAME_CNT_W-1:0]  m_op_cnt;
    logic         m_detect_done;
    logic         m_speed_done;
    logic         m_timeout;
    link_speed_t  m_speed;
    logic         m_ddr;
    logic [8:0]   exp_byte;
    logic [4:0]   exp_speed;
    speed_capab_t common_capab;

    logic [31:0]  rng_state = 32'h14b4be35;
    int           cycle_count = 0;
    int           check_count = 0;
    int           mismatch_count = 0;

    ltpi_frame_tx ltpi_frame_tx_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // {found, index} of the highest set speed bit
    function automatic logic [4:0] highest_common(input speed_capab_t sel);
        logic [4:0] result;
        result = '0;
        for (int i = 0; i < 12; i++) begin
            if (sel[i]) begin
                result = {1'b1, 4'(i)};
            end
        end
        return result;
    endfunction

    // {write, value} for the current state and offset
    function automatic logic [8:0] expected_byte();
        speed_capab_t capab;
        frm_byte_t    sub;
        int           pos;
        pos = int'(frm_offset);
        case (link_state)
            st_comma_hunting, st_wait_link_detect_locked,
            st_wait_link_speed_locked, st_link_speed_change: begin
                capab = local_speed_capab;
                sub = SUB_DETECT;
                if (link_state == st_wait_link_speed_locked ||
                    link_state == st_link_speed_change) begin
                    capab = local_speed_capab & remote_speed_capab;
                    sub = SUB_SPEED;
                end
                case (pos)
                    0: return {1'b1, K28_5};
                    1: return {1'b1, sub};
                    2: return {1'b1, LTPI_VERSION};
                    3: return {1'b1, capab[7:0]};
                    4: return {1'b1, capab[15:8]};
                    default: return '0;
                endcase
            end
            st_wait_link_advertise_locked, st_wait_in_advertise: begin
                if (pos == 0) return {1'b1, K28_6};
                if (pos == 1) return {1'b1, SUB_ADVERTISE};
                if (pos == 2) return {1'b1, platform_id[15:8]};
                if (pos == 3) return {1'b1, platform_id[7:0]};
                if (pos == 4) return {1'b1, CAPAB_TYPE_DEFAULT};
                if (pos <= 12) return {1'b1, advertise_capab[8*(pos-5) +: 8]};
                if (pos <= 14) return {1'b1, 8'h00};
                return '0;
            end
            st_operational: begin
                if (pos < FRAME_BYTES) return {1'b1, operational_frame[8*pos +: 8]};
                return '0;
            end
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [119:0] got,
                               input logic [119:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_cleared(input logic ddr_exp);
        check_value("frame_tx", frame_tx, '0);
        check_value("detect_frm_cnt", detect_frm_cnt, '0);
        check_value("speed_frm_cnt", speed_frm_cnt, '0);
        check_value("advertise_frm_cnt", advertise_frm_cnt, '0);
        check_value("operational_frm_cnt", operational_frm_cnt, '0);
        check_value("detect_frames_done", detect_frames_done, '0);
        check_value("speed_frames_done", speed_frames_done, '0);
        check_value("speed_timeout", speed_timeout, '0);
        check_value("operational_speed", operational_speed, base_freq_x1);
        check_value("ddr_mode", ddr_mode, ddr_exp);
    endtask

    // One frame of 16 offsets, new random contents at offset 0
    task automatic send_frame(input link_state_t state, input speed_capab_t capab_force);
        for (int k = 0; k < 16; k++) begin
            @(posedge clk);
            link_state <= state;
            frm_offset <= frm_offset_t'(k);
            if (k == 0) begin
                local_speed_capab  <= 16'(next_rand()) | capab_force;
                remote_speed_capab <= (16'(next_rand()) & 16'(next_rand()) &
                                       16'(next_rand())) | capab_force;
                platform_id        <= 16'(next_rand());
                advertise_capab    <= {next_rand(), next_rand()};
                operational_frame  <= 120'({next_rand(), next_rand(), next_rand(), next_rand()});
            end
        end
    endtask

    task automatic run_frames(input link_state_t state, input int count);
        repeat (count) send_frame(state, '0);
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_frame <= '0;
            m_end_seen <= 1'b0;
            m_detect_cnt <= '0;
            m_speed_cnt <= '0;
            m_adv_cnt <= '0;
            m_op_cnt <= '0;
            m_detect_done <= 1'b0;
            m_speed_done <= 1'b0;
            m_timeout <= 1'b0;
            m_speed <= base_freq_x1;
            m_ddr <= 1'b0;
        end else if (link_state == st_init || link_state == st_link_lost_err) begin
            m_frame <= '0;
            m_end_seen <= 1'b0;
            m_detect_cnt <= '0;
            m_speed_cnt <= '0;
            m_adv_cnt <= '0;
            m_op_cnt <= '0;
            m_detect_done <= (m_detect_cnt >= DETECT_DONE_CNT);
            m_speed_done <= 1'b0;
            m_timeout <= 1'b0;
            m_speed <= base_freq_x1;
            if (link_state == st_init) begin
                m_ddr <= 1'b0;
            end
        end else begin
            exp_byte = expected_byte();
            if (exp_byte[8]) begin
                m_frame[8*frm_offset +: 8] <= exp_byte[7:0];
            end
            m_end_seen <= (frm_offset == 4'd15);
            if (frm_offset == 4'd15 && !m_end_seen) begin
                case (link_state)
                    st_wait_link_detect_locked: m_detect_cnt <= m_detect_cnt + 1'b1;
                    st_wait_link_speed_locked, st_link_speed_change: begin
                        m_speed_cnt <= m_speed_cnt + 1'b1;
                    end
                    st_wait_link_advertise_locked, st_wait_in_advertise: begin
                        m_adv_cnt <= m_adv_cnt + 1'b1;
                    end
                    st_operational: m_op_cnt <= m_op_cnt + 1'b1;
                    default: ;
                endcase
            end
            m_detect_done <= (m_detect_cnt >= DETECT_DONE_CNT);
            m_speed_done <= (m_speed_cnt >= SPEED_DONE_CNT);
            if (m_speed_cnt >= SPEED_TIMEOUT_CNT) begin
                m_timeout <= 1'b1;
            end
            if (link_state == st_wait_link_detect_locked) begin
                common_capab = local_speed_capab & remote_speed_capab;
                exp_speed = highest_common(common_capab);
                if (exp_speed[4]) begin
                    m_speed <= link_speed_t'(exp_speed[3:0]);
                end
                m_ddr <= common_capab[15];
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            check_value("frame_tx", frame_tx, m_frame);
            check_value("detect_frm_cnt", detect_frm_cnt, m_detect_cnt);
            check_value("speed_frm_cnt", speed_frm_cnt, m_speed_cnt);
            check_value("advertise_frm_cnt", advertise_frm_cnt, m_adv_cnt);
            check_value("operational_frm_cnt", operational_frm_cnt, m_op_cnt);
            check_value("detect_frames_done", detect_frames_done, m_detect_done);
            check_value("speed_frames_done", speed_frames_done, m_speed_done);
            check_value("speed_timeout", speed_timeout, m_timeout);
            check_value("operational_speed", operational_speed, m_speed);
            check_value("ddr_mode", ddr_mode, m_ddr);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        reset = 1'b1;
        link_state = st_init;
        frm_offset = '0;
        local_speed_capab = '0;
        remote_speed_capab = '0;
        platform_id = '0;
        advertise_capab = '0;
        operational_frame = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_cleared(1'b0);

        run_frames(st_comma_hunting, HUNT_FRAMES);
        run_frames(st_wait_link_detect_locked, DETECT_FRAMES - 1);
        // Last detect frame sets DDR and the top speed on both ends
        send_frame(st_wait_link_detect_locked, 16'h8800);
        @(negedge clk);
        check_value("detect_frm_cnt", detect_frm_cnt, DETECT_FRAMES - 1);
        check_value("detect_frames_done", detect_frames_done, 1'b1);
        check_value("ddr_mode", ddr_mode, 1'b1);
        check_value("operational_speed", operational_speed, base_freq_x40);

        run_frames(st_wait_link_speed_locked, SPEED_LOCK_FRAMES);
        run_frames(st_link_speed_change, SPEED_CHANGE_FRAMES);
        @(negedge clk);
        check_value("speed_frames_done", speed_frames_done, 1'b1);
        check_value("speed_timeout", speed_timeout, 1'b1);

        run_frames(st_wait_link_advertise_locked, ADV_FRAMES);
        run_frames(st_wait_in_advertise, ADV_FRAMES);
        run_frames(st_operational, OP_FRAMES);
        @(negedge clk);
        check_value("advertise_frm_cnt", advertise_frm_cnt, 2 * ADV_FRAMES);
        check_value("operational_frm_cnt", operational_frm_cnt, OP_FRAMES - 1);
        check_value("speed_timeout", speed_timeout, 1'b1);

        run_frames(st_link_lost_err, CLEAR_FRAMES);
        @(negedge clk);
        check_cleared(1'b1);
        run_frames(st_init, CLEAR_FRAMES);
        @(negedge clk);
        check_cleared(1'b0);

        $display("Summary: %0d checks, %0d mismatches", check_count, mismatch_count);
        if (mismatch_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
source/ltpi_tx_pkg.sv
source/link_speed_resolver.sv
source/frame_byte_generator.sv
source/tx_frame_buffer.sv
source/frame_sent_tracker.sv
source/ltpi_frame_tx.sv
verification/tb_ltpi_frame_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
rm -f sim.log
verilator --binary --assert -Wno-fatal -f flist.f --top-module tb_ltpi_frame_tx -o sim_ltpi \
    && ./obj_dir/sim_ltpi 2>&1 | tee sim.log \
    && ! grep -q "TESTS FAILED" sim.log \
    || { echo "Simulation failed"; exit 1; }
